//--- verilog.f
+incdir+include
rtl/sram_pkg.sv
rtl/tc_sram.sv
rtl/sram.sv
rtl/sram_port_arbiter.sv
rtl/sram_subsystem.sv
bench/tb_clock_gen.sv
bench/sram_asserts.sv
bench/tb_sram_subsystem.sv

//--- bench/tb_sram_subsystem.sv
// Testbench for the shared SRAM subsystem
`include "sram_config.svh"

module tb_sram_subsystem;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int unsigned NUM_LANES = $bits(sram_pkg::be_t);
   localparam int unsigned BYTE_W    = `SRAM_BYTE_WIDTH;
   localparam int unsigned GNT_LIMIT = 16;
   localparam int unsigned RSP_LIMIT = 4;

   logic                      clk;
   logic                      reset;
   logic [1:0]                req;
   sram_pkg::port_req_t [1:0] req_fields;
   logic [1:0]                gnt;
   logic [1:0]                rvalid;
   sram_pkg::port_rsp_t       rsp;

   // Reference memory, cleared at time zero like the DUT
   sram_pkg::data_t     model_data [`SRAM_NUM_WORDS];
   sram_pkg::user_t     model_user [`SRAM_NUM_WORDS];
   // Expected read results per port
   sram_pkg::port_rsp_t exp_q [2][$];
   // Round-robin history and reads due next cycle
   sram_pkg::port_sel_t model_last;
   logic [1:0]          rd_due;
   logic [31:0]         rng_state = 32'hb7dc_5e00;

   // Monitor scratch
   sram_pkg::port_sel_t win;
   logic [1:0]          exp_gnt;
   sram_pkg::port_req_t win_cmd;
   sram_pkg::port_rsp_t exp_rsp;

   tb_clock_gen i_tb_clock_gen (
      .clk_o ( clk )
   );

   sram_subsystem dut0 (
      .clk_i        ( clk        ),
      .reset_i      ( reset      ),
      .req_i        ( req        ),
      .req_fields_i ( req_fields ),
      .gnt_o        ( gnt        ),
      .rvalid_o     ( rvalid     ),
      .rsp_o        ( rsp        )
   );

   function logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function sram_pkg::data_t rand_word();
      return {lcg_next(), lcg_next()};
   endfunction

   task stop_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task compare_values(input string name, input logic [127:0] got, input logic [127:0] exp);
      if (got !== exp) begin
         stop_run($sformatf("mismatch at %0d ns: %s is %0h, expected %0h",
                            $time, name, got, exp));
      end
   endtask

   // Watch the arbiter checker
   always @(dut0.i_sram_port_arbiter.i_sram_asserts.fail_count) begin
      if (dut0.i_sram_port_arbiter.i_sram_asserts.fail_count != 0) begin
         stop_run("A protocol assertion on the arbiter failed");
      end
   end

   // Byte lane merge into the model
   task model_write(input sram_pkg::port_req_t cmd);
      for (int l = 0; l < NUM_LANES; l++) begin
         if (cmd.be[l]) begin
            model_data[cmd.addr][l*BYTE_W +: BYTE_W] = cmd.wdata[l*BYTE_W +: BYTE_W];
            model_user[cmd.addr][l*BYTE_W +: BYTE_W] = cmd.wuser[l*BYTE_W +: BYTE_W];
         end
      end
   endtask

   // Sample 1 ns after the falling edge
   // Grant then belongs to the coming rising edge
   always @(negedge clk) begin
      #1;
      if (reset) begin
         model_last = 1'b1;
         rd_due = 2'b00;
         exp_q[0].delete();
         exp_q[1].delete();
      end else begin
         // Reads granted at the previous edge
         compare_values("rvalid_o", rvalid, rd_due);
         for (int p = 0; p < 2; p++) begin
            if (rd_due[p]) begin
               exp_rsp = exp_q[p].pop_front();
               compare_values($sformatf("rsp_o for port %0d", p), rsp, exp_rsp);
            end
         end
         // Lone requester wins, else the one not served last
         win = (req == 2'b11) ? ~model_last : req[1];
         exp_gnt = 2'b00;
         rd_due = 2'b00;
         if (req != 2'b00) begin
            exp_gnt[win] = 1'b1;
         end
         compare_values("gnt_o", gnt, exp_gnt);
         if (req != 2'b00) begin
            model_last = win;
            win_cmd = req_fields[win];
            if (win_cmd.we) begin
               model_write(win_cmd);
            end else begin
               // Data as stored before the edge
               exp_rsp.rdata = model_data[win_cmd.addr];
               exp_rsp.ruser = model_user[win_cmd.addr];
               exp_q[win].push_back(exp_rsp);
               rd_due[win] = 1'b1;
            end
         end
      end
   end

   function sram_pkg::port_req_t make_cmd(input logic we, input sram_pkg::addr_t addr,
                                          input sram_pkg::be_t be);
      sram_pkg::port_req_t cmd;
      cmd.we    = we;
      cmd.addr  = addr;
      cmd.be    = be;
      cmd.wdata = rand_word();
      cmd.wuser = rand_word();
      return cmd;
   endfunction

   // Raise the request and hold it until granted
   task automatic do_access(input int p, input sram_pkg::port_req_t cmd, output int waited);
      waited = 0;
      @(negedge clk);
      req[p] = 1'b1;
      req_fields[p] = cmd;
      #1;
      while (!gnt[p]) begin
         waited++;
         if (waited > GNT_LIMIT) begin
            stop_run($sformatf("The grant for port %0d never arrived", p));
         end
         @(negedge clk);
         #1;
      end
   endtask

   task automatic drop_req(input int p);
      @(negedge clk);
      req[p] = 1'b0;
      req_fields[p] = '0;
   endtask

   task automatic wait_rvalid(input int p);
      int cycles;
      cycles = 0;
      #1;
      while (!rvalid[p]) begin
         cycles++;
         if (cycles > RSP_LIMIT) begin
            stop_run($sformatf("The read response for port %0d never arrived", p));
         end
         @(negedge clk);
         #1;
      end
   endtask

   task automatic read_word(input int p, input sram_pkg::addr_t addr);
      int waited;
      do_access(p, make_cmd(1'b0, addr, sram_pkg::be_t'(lcg_next())), waited);
      drop_req(p);
      wait_rvalid(p);
   endtask

   task automatic write_word(input int p, input sram_pkg::addr_t addr, input sram_pkg::be_t be);
      int waited;
      do_access(p, make_cmd(1'b1, addr, be), waited);
      drop_req(p);
   endtask

   task automatic apply_reset();
      @(negedge clk);
      reset = 1'b1;
      repeat (2) @(negedge clk);
      reset = 1'b0;
   endtask

   // Quiet outputs, then reads of untouched words
   task automatic check_idle_after_reset();
      #1;
      compare_values("gnt_o", gnt, 2'b00);
      compare_values("rvalid_o", rvalid, 2'b00);
      for (int i = 0; i < 8; i++) begin
         read_word(i % 2, sram_pkg::addr_t'(lcg_next()));
      end
   endtask

   // Read back from the other port
   task automatic run_full_writes();
      sram_pkg::addr_t addr;
      for (int i = 0; i < 16; i++) begin
         addr = sram_pkg::addr_t'(lcg_next());
         write_word(i % 2, addr, '1);
         read_word((i + 1) % 2, addr);
      end
   endtask

   task automatic run_partial_writes();
      sram_pkg::addr_t addr;
      for (int i = 0; i < 16; i++) begin
         addr = sram_pkg::addr_t'(lcg_next());
         write_word(0, addr, '1);
         write_word(1, addr, sram_pkg::be_t'(lcg_next()));
         read_word(i % 2, addr);
      end
   endtask

   // Both ports request every cycle
   // Port 0 wins the first conflict, then each port waits one cycle
   task automatic run_conflicts();
      apply_reset();
      fork
         begin
            int w0;
            for (int i = 0; i < 12; i++) begin
               do_access(0, make_cmd(lcg_next() % 2, 8'(i), '1), w0);
               compare_values("port 0 grant wait cycles", w0, (i == 0) ? 0 : 1);
            end
            drop_req(0);
         end
         begin
            int w1;
            for (int i = 0; i < 12; i++) begin
               do_access(1, make_cmd(lcg_next() % 2, 8'(i), '1), w1);
               compare_values("port 1 grant wait cycles", w1, 1);
            end
            drop_req(1);
         end
      join
   endtask

   // Random reads and writes over a small window with idle gaps
   task automatic port_traffic(input int p, input int n);
      logic [31:0]         r;
      sram_pkg::be_t       be;
      sram_pkg::port_req_t cmd;
      int                  waited;
      for (int i = 0; i < n; i++) begin
         r = lcg_next();
         if (r[2:0] == 3'd0) begin
            drop_req(p);
            repeat (r[4:3]) @(negedge clk);
         end
         be = r[21] ? '1 : r[20:13];
         cmd = make_cmd(r[5], {3'b000, r[12:8]}, be);
         do_access(p, cmd, waited);
      end
      drop_req(p);
   endtask

   task automatic run_random_mix();
      fork
         port_traffic(0, 150);
         port_traffic(1, 150);
      join
   endtask

   initial begin
      reset = 1'b1;
      req = '0;
      req_fields = '0;
      for (int w = 0; w < `SRAM_NUM_WORDS; w++) begin
         model_data[w] = '0;
         model_user[w] = '0;
      end
      repeat (2) @(negedge clk);
      reset = 1'b0;
      check_idle_after_reset();
      run_full_writes();
      run_partial_writes();
      run_conflicts();
      run_random_mix();
      repeat (3) @(negedge clk);
      $display("STATUS: PASS");
      $finish;
   end

endmodule : tb_sram_subsystem

//--- bench/sram_asserts.sv
// Arbiter protocol assertions
module sram_asserts (
   input logic                clk_i,
   input logic                reset_i,
   input logic [1:0]          port_req_i,
   input logic [1:0]          port_gnt_i,
   input logic [1:0]          port_rvalid_i,
   input sram_pkg::port_req_t mem_cmd_i
);
   timeunit 1ns;
   timeprecision 100ps;

   // Number of assertion failures seen so far
   int fail_count = 0;

   // Never two grants in the same cycle
   gnt_onehot_a : assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(port_gnt_i))
   else begin
      $error("both ports granted in the same cycle");
      fail_count++;
   end

   // A grant always answers a request
   gnt_has_req_a : assert property (@(posedge clk_i) disable iff (reset_i)
      (port_gnt_i & ~port_req_i) == 2'b00)
   else begin
      $error("grant without a matching request");
      fail_count++;
   end

   // Read data comes back on the granted port one cycle later
   for (genvar p = 0; p < 2; p++) begin : gen_rd_timing
      rd_rvalid_a : assert property (@(posedge clk_i) disable iff (reset_i)
         port_gnt_i[p] && !mem_cmd_i.we |=> port_rvalid_i[p])
      else begin
         $error("read granted on port %0d without rvalid one cycle later", p);
         fail_count++;
      end
   end

endmodule : sram_asserts

bind sram_port_arbiter sram_asserts i_sram_asserts (
   .clk_i         ( clk_i         ),
   .reset_i       ( reset_i       ),
   .port_req_i    ( port_req_i    ),
   .port_gnt_i    ( port_gnt_o    ),
   .port_rvalid_i ( port_rvalid_o ),
   .mem_cmd_i     ( mem_cmd_o     )
);

//--- bench/tb_clock_gen.sv
// Testbench clock source
module tb_clock_gen #(
   parameter int unsigned HALF_PERIOD_NS = 2
) (
   output logic clk_o
);
   timeunit 1ns;
   timeprecision 100ps;

   // Free running, 4 ns period by default
   initial begin
      clk_o = 1'b0;
      forever begin
         #(HALF_PERIOD_NS) clk_o = ~clk_o;
      end
   end

endmodule : tb_clock_gen

//--- rtl/sram_subsystem.sv
// Shared SRAM subsystem top
`include "sram_config.svh"

module sram_subsystem (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic [1:0]                req_i,
   input  sram_pkg::port_req_t [1:0] req_fields_i,
   output logic [1:0]                gnt_o,
   output logic [1:0]                rvalid_o,
   output sram_pkg::port_rsp_t       rsp_o
);

   // Arbiter to macro
   logic                mem_req;
   sram_pkg::port_req_t mem_cmd;

   // Macro back to arbiter
   sram_pkg::data_t     mem_rdata;
   sram_pkg::user_t     mem_ruser;

   // Port 0 is the core side and port 1 the refill side
   sram_port_arbiter i_sram_port_arbiter (
      .clk_i         ( clk_i        ),
      .reset_i       ( reset_i      ),
      .port_req_i    ( req_i        ),
      .port_cmd_i    ( req_fields_i ),
      .port_gnt_o    ( gnt_o        ),
      .port_rvalid_o ( rvalid_o     ),
      .mem_req_o     ( mem_req      ),
      .mem_cmd_o     ( mem_cmd      ),
      .mem_rdata_i   ( mem_rdata    ),
      .mem_ruser_i   ( mem_ruser    ),
      .rsp_o         ( rsp_o        )
   );

   // User words have the data width
   sram #(
      .DATA_WIDTH ( `SRAM_DATA_WIDTH ),
      .BYTE_WIDTH ( `SRAM_BYTE_WIDTH ),
      .USER_WIDTH ( `SRAM_DATA_WIDTH ),
      .USER_EN    ( `SRAM_USER_EN    ),
      .NUM_WORDS  ( `SRAM_NUM_WORDS  ),
      .SIM_INIT   ( `SRAM_SIM_INIT   )
   ) i_sram (
      .clk_i   ( clk_i         ),
      .reset_i ( reset_i       ),
      .req_i   ( mem_req       ),
      .we_i    ( mem_cmd.we    ),
      .addr_i  ( mem_cmd.addr  ),
      .wuser_i ( mem_cmd.wuser ),
      .wdata_i ( mem_cmd.wdata ),
      .be_i    ( mem_cmd.be    ),
      .ruser_o ( mem_ruser     ),
      .rdata_o ( mem_rdata     )
   );

endmodule : sram_subsystem

//--- rtl/sram_port_arbiter.sv
// Two-port round-robin arbiter
module sram_port_arbiter (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic [1:0]                port_req_i,
   input  sram_pkg::port_req_t [1:0] port_cmd_i,
   output logic [1:0]                port_gnt_o,
   output logic [1:0]                port_rvalid_o,
   output logic                      mem_req_o,
   output sram_pkg::port_req_t       mem_cmd_o,
   input  sram_pkg::data_t           mem_rdata_i,
   input  sram_pkg::user_t           mem_ruser_i,
   output sram_pkg::port_rsp_t       rsp_o
);

   // Port granted most recently
   sram_pkg::port_sel_t last_q;

   // Winner of the current cycle
   sram_pkg::port_sel_t sel;

   // Read issued last cycle and the port that asked for it
   logic                rd_pend_q;
   sram_pkg::port_sel_t rd_port_q;

   // Pick the winner
   // A lone requester always wins
   // On a conflict the port not served last time goes first
   always_comb begin
      sel = 1'b0;
      if (port_req_i[0] && port_req_i[1]) begin
         sel = ~last_q;
      end else if (port_req_i[1]) begin
         sel = 1'b1;
      end
   end

   // Memory sees a request whenever anybody asks
   assign mem_req_o = |port_req_i;
   assign mem_cmd_o = port_cmd_i[sel];

   // Grant follows the request in the same cycle
   always_comb begin
      port_gnt_o = '0;
      if (mem_req_o) begin
         port_gnt_o[sel] = 1'b1;
      end
   end

   // Round-robin history
   // Port 0 wins the first conflict after reset
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         last_q <= 1'b1;
      end else if (mem_req_o) begin
         last_q <= sel;
      end
   end

   // Track a granted read for one cycle
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rd_pend_q <= 1'b0;
      end else begin
         rd_pend_q <= mem_req_o && !mem_cmd_o.we;
      end
   end

   // Port identity only matters while a read is pending
   always_ff @(posedge clk_i) begin
      rd_port_q <= sel;
   end

   // Route the pulse back to the port that issued the read
   always_comb begin
      port_rvalid_o = '0;
      if (rd_pend_q) begin
         port_rvalid_o[rd_port_q] = 1'b1;
      end
   end

   // Response bus is shared by both ports
   assign rsp_o.rdata = mem_rdata_i;
   assign rsp_o.ruser = mem_ruser_i;

endmodule : sram_port_arbiter

//--- rtl/sram.sv
// Data and user RAM wrapper
module sram #(
   parameter int unsigned DATA_WIDTH = 64,
   parameter int unsigned BYTE_WIDTH = 8,
   parameter int unsigned USER_WIDTH = 64,
   parameter int unsigned USER_EN    = 0,
   parameter int unsigned NUM_WORDS  = 256,
   parameter string       SIM_INIT   = "none"
) (
   input  logic            clk_i,
   input  logic            reset_i,
   input  logic            req_i,
   input  logic            we_i,
   input  sram_pkg::addr_t addr_i,
   input  sram_pkg::user_t wuser_i,
   input  sram_pkg::data_t wdata_i,
   input  sram_pkg::be_t   be_i,
   output sram_pkg::user_t ruser_o,
   output sram_pkg::data_t rdata_o
);

   // Data array
   tc_sram #(
      .NumWords  ( NUM_WORDS  ),
      .DataWidth ( DATA_WIDTH ),
      .ByteWidth ( BYTE_WIDTH ),
      .SimInit   ( SIM_INIT   )
   ) i_tc_sram (
      .clk_i   ( clk_i   ),
      .reset_i ( reset_i ),
      .req_i   ( req_i   ),
      .we_i    ( we_i    ),
      .addr_i  ( addr_i  ),
      .be_i    ( be_i    ),
      .wdata_i ( wdata_i ),
      .rdata_o ( rdata_o )
   );

   if (USER_EN > 0) begin : gen_mem_user
      // User array follows the data array exactly
      // Same address, strobe and byte enables
      tc_sram #(
         .NumWords  ( NUM_WORDS  ),
         .DataWidth ( DATA_WIDTH ),
         .ByteWidth ( BYTE_WIDTH ),
         .SimInit   ( SIM_INIT   )
      ) i_tc_sram_user (
         .clk_i   ( clk_i   ),
         .reset_i ( reset_i ),
         .req_i   ( req_i   ),
         .we_i    ( we_i    ),
         .addr_i  ( addr_i  ),
         .be_i    ( be_i    ),
         .wdata_i ( wuser_i ),
         .rdata_o ( ruser_o )
      );

      // Shared byte enables only make sense for equal widths
      if (USER_WIDTH != DATA_WIDTH) begin : gen_err_user_width
         $fatal(1, "sram: USER_WIDTH must equal DATA_WIDTH when USER_EN is set");
      end
   end else begin : gen_no_user
      // No user storage so reads return zero
      assign ruser_o = '0;
   end

endmodule : sram

//--- rtl/tc_sram.sv
// Single-port RAM model
module tc_sram #(
   parameter int unsigned NumWords  = 256,
   parameter int unsigned DataWidth = 64,
   parameter int unsigned ByteWidth = 8,
   parameter string       SimInit   = "none"
) (
   input  logic            clk_i,
   input  logic            reset_i,
   input  logic            req_i,
   input  logic            we_i,
   input  sram_pkg::addr_t addr_i,
   input  sram_pkg::be_t   be_i,
   input  sram_pkg::data_t wdata_i,
   output sram_pkg::data_t rdata_o
);

   // Number of byte lanes in one word
   localparam int unsigned NumLanes = DataWidth / ByteWidth;

   // Storage array
   logic [DataWidth-1:0] mem_q [NumWords];

   // Registered read word
   sram_pkg::data_t rdata_q;

   // Port types have to agree with the parameters
   if (DataWidth != $bits(sram_pkg::data_t)) begin : gen_data_width_err
      $fatal(1, "tc_sram: DataWidth differs from the data word type");
   end

   if (NumLanes != $bits(sram_pkg::be_t)) begin : gen_lane_err
      $fatal(1, "tc_sram: byte enable width differs from the lane count");
   end

   if ($clog2(NumWords) != $bits(sram_pkg::addr_t)) begin : gen_depth_err
      $fatal(1, "tc_sram: NumWords does not fit the address type");
   end

   if (SimInit != "zeros" && SimInit != "none") begin : gen_init_err
      $fatal(1, "tc_sram: only zeros and none are supported as SimInit");
   end

   // Zero fill happens once at time zero
   // Contents are never touched by reset
   initial begin
      if (SimInit == "zeros") begin
         for (int unsigned w = 0; w < NumWords; w++) begin
            mem_q[w] = '0;
         end
      end
   end

   // Write port
   // Only lanes with their enable set are updated
   always @(posedge clk_i) begin
      if (req_i && we_i) begin
         for (int unsigned l = 0; l < NumLanes; l++) begin
            if (be_i[l]) begin
               mem_q[addr_i][l*ByteWidth +: ByteWidth] <= wdata_i[l*ByteWidth +: ByteWidth];
            end
         end
      end
   end

   // Read port with one cycle of latency
   // Output keeps the last word while idle or writing
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rdata_q <= '0;
      end else if (req_i && !we_i) begin
         rdata_q <= mem_q[addr_i];
      end
   end

   assign rdata_o = rdata_q;

endmodule : tc_sram

//--- rtl/sram_pkg.sv
// Memory subsystem types
`include "sram_config.svh"

package sram_pkg;

   // One data word as stored in the macro
   typedef logic [`SRAM_DATA_WIDTH-1:0] data_t;

   // User word sits beside the data word
   // Same width as the data word
   typedef logic [`SRAM_DATA_WIDTH-1:0] user_t;

   // One enable per byte lane
   typedef logic [`SRAM_BE_WIDTH-1:0] be_t;

   // Word address into the array
   typedef logic [`SRAM_ADDR_WIDTH-1:0] addr_t;

   // Names one of the two requesters
   typedef logic port_sel_t;

   // Command presented by a requester
   typedef struct packed {
      logic  we;
      addr_t addr;
      data_t wdata;
      user_t wuser;
      be_t   be;
   } port_req_t;

   // Read result returned to a requester
   typedef struct packed {
      data_t rdata;
      user_t ruser;
   } port_rsp_t;

endpackage : sram_pkg

//--- include/sram_config.svh
// Shared memory configuration
// Widths, depth and init style
`ifndef SRAM_CONFIG_SVH
`define SRAM_CONFIG_SVH

// Width of one data word in bits
`define SRAM_DATA_WIDTH 64

// Bits covered by one byte enable
`define SRAM_BYTE_WIDTH 8

// Number of words in the macro
`define SRAM_NUM_WORDS 256

// Set to 1 to keep a user word next to every data word
`define SRAM_USER_EN 1

// Start-up contents of the arrays
// Either "zeros" or "none"
`define SRAM_SIM_INIT "zeros"

// Derived sizes used by the package
`define SRAM_BE_WIDTH (`SRAM_DATA_WIDTH / `SRAM_BYTE_WIDTH)
`define SRAM_ADDR_WIDTH $clog2(`SRAM_NUM_WORDS)

`endif
